// File: sim/tb_jtag_dm.sv
// DTM side allows one request in flight; hart and memory are plain arrays, memory holds 64 words
`timescale 1ns/1ps
`default_nettype none

`include "dm_cfg.svh"

module tb_jtag_dm;
    import dm_pkg::*;

    localparam logic [31:0] SEED           = 32'h67be_f00b;
    // about 46 transactions of up to 25 cycles each, plus margin
    localparam int          MAX_CYCLES     = 3000;
    localparam logic [31:0] DMSTATUS_RESET = 32'h0043_0c82;
    localparam logic [31:0] DMSTATUS_HALT  = 32'h0043_0382;
    localparam logic [31:0] ABSCS_RESET    = 32'h0100_0003;
    // sbcs reset value plus sbautoincrement and sbreadonaddr
    localparam logic [31:0] SBCS_AUTO      = 32'h2004_0404 | 32'h0011_0000;
    localparam logic [31:0] SB_BASE        = 32'h0000_0040;

    logic                     clk_i = 1'b0;
    logic                     rst_n;
    logic                     dtm_req_valid_i;
    logic [`DMI_REQ_BITS-1:0] dtm_req_data_i;
    logic                     dtm_ack_i;
    wire                      dm_ack_o;
    wire                      dm_resp_valid_o;
    wire  [`DMI_REQ_BITS-1:0] dm_resp_data_o;
    wire                      dm_reg_we_o;
    wire  [4:0]               dm_reg_addr_o;
    wire  [31:0]              dm_reg_wdata_o;
    wire  [31:0]              reg_rdata;
    wire                      dm_mem_we_o;
    wire  [31:0]              dm_mem_addr_o;
    wire  [31:0]              dm_mem_wdata_o;
    wire  [31:0]              mem_rdata;
    wire                      dm_op_req_o;
    wire                      dm_halt_req_o;
    wire                      dm_reset_req_o;
    wire                      status_read;

    logic [31:0]              hart_regs [32];
    logic [31:0]              hart_exp [32];
    logic [31:0]              mem_words [64];
    logic [`DMI_REQ_BITS-1:0] exp_resp;
    logic                     exp_halt;
    logic [4:0]               exp_reg_addr;
    logic [31:0]              exp_reg_wdata;
    logic [31:0]              exp_mem_addr;
    logic [31:0]              exp_mem_wdata;
    int                       exp_reg_we_cnt;
    int                       exp_mem_we_cnt;
    int                       exp_reset_cnt;
    int                       reg_we_cnt;
    int                       mem_we_cnt;
    int                       reset_cnt;
    int                       req_cnt;
    int                       resp_cnt;
    int                       cycle_cnt = 0;
    logic                     resp_valid_q;

    always #50 clk_i = ~clk_i;

    jtag_dm u_jtag_dm (
        .clk_i           (clk_i),
        .rst_n           (rst_n),
        .dtm_req_valid_i (dtm_req_valid_i),
        .dtm_req_data_i  (dtm_req_data_i),
        .dm_ack_o        (dm_ack_o),
        .dtm_ack_i       (dtm_ack_i),
        .dm_resp_valid_o (dm_resp_valid_o),
        .dm_resp_data_o  (dm_resp_data_o),
        .dm_reg_we_o     (dm_reg_we_o),
        .dm_reg_addr_o   (dm_reg_addr_o),
        .dm_reg_wdata_o  (dm_reg_wdata_o),
        .dm_reg_rdata_i  (reg_rdata),
        .dm_mem_we_o     (dm_mem_we_o),
        .dm_mem_addr_o   (dm_mem_addr_o),
        .dm_mem_wdata_o  (dm_mem_wdata_o),
        .dm_mem_rdata_i  (mem_rdata),
        .dm_op_req_o     (dm_op_req_o),
        .dm_halt_req_o   (dm_halt_req_o),
        .dm_reset_req_o  (dm_reset_req_o)
    );

    function automatic logic [31:0] hart_fill(input int idx);
        return 32'h5a00_0000 ^ (idx * 32'h0001_0203);
    endfunction

    task automatic abort_run(input string detail);
        $display("CHECKS FAILED");
        $display("%s", detail);
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic mismatch(input string signal, input logic [63:0] expected,
                            input logic [63:0] got);
        abort_run($sformatf("MISMATCH time=%0t signal=%s expected=%0h got=%0h",
                            $time, signal, expected, got));
    endtask

    // one full request and response exchange, as the DTM performs it
    task automatic dmi_access(input logic [`DMI_ADDR_BITS-1:0] addr, input dmi_op_e op,
                              input logic [31:0] wdata, input logic [31:0] exp_rdata);
        int delay;
        delay = $urandom_range(5);
        @(negedge clk_i);
        while (dm_ack_o)
            @(negedge clk_i);
        exp_resp = {addr, (op == DMI_OP_READ) ? exp_rdata : 32'h0, 2'b00};
        req_cnt = req_cnt + 1;
        dtm_req_data_i = {addr, wdata, op};
        dtm_req_valid_i = 1'b1;
        while (!dm_ack_o)
            @(negedge clk_i);
        dtm_req_valid_i = 1'b0;
        while (!dm_resp_valid_o)
            @(negedge clk_i);
        repeat (delay) @(negedge clk_i);
        dtm_ack_i = 1'b1;
        while (dm_resp_valid_o)
            @(negedge clk_i);
        dtm_ack_i = 1'b0;
    endtask

    task automatic write_dm(input logic [`DMI_ADDR_BITS-1:0] addr, input logic [31:0] data);
        dmi_access(addr, DMI_OP_WRITE, data, 32'h0);
    endtask

    task automatic read_check(input logic [`DMI_ADDR_BITS-1:0] addr, input logic [31:0] exp);
        dmi_access(addr, DMI_OP_READ, $urandom, exp);
    endtask

    // hart and memory models and strobe counters
    assign reg_rdata = hart_regs[dm_reg_addr_o];
    assign mem_rdata = mem_words[dm_mem_addr_o[7:2]];

    // dmstatus polls leave dm_op_req_o low
    assign status_read = (dtm_req_data_i[`DMI_REQ_BITS-1 -: `DMI_ADDR_BITS] == DM_DMSTATUS) &&
                         (dtm_req_data_i[`DMI_OP_BITS-1:0] == DMI_OP_READ);

    always @(posedge clk_i) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++)
                hart_regs[i] <= hart_fill(i);
            for (int i = 0; i < 64; i++)
                mem_words[i] <= 32'hc0de_0000 + i * 32'h0004_0101;
            reg_we_cnt   <= 0;
            mem_we_cnt   <= 0;
            reset_cnt    <= 0;
            resp_cnt     <= 0;
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= dm_resp_valid_o;
            if (dm_resp_valid_o && !resp_valid_q)
                resp_cnt <= resp_cnt + 1;
            if (dm_reg_we_o) begin
                hart_regs[dm_reg_addr_o] <= dm_reg_wdata_o;
                reg_we_cnt <= reg_we_cnt + 1;
            end
            if (dm_mem_we_o) begin
                mem_words[dm_mem_addr_o[7:2]] <= dm_mem_wdata_o;
                mem_we_cnt <= mem_we_cnt + 1;
            end
            if (dm_reset_req_o)
                reset_cnt <= reset_cnt + 1;
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES)
            abort_run("timeout: the test sequence did not finish within the cycle limit");
    end

    reset_outputs_low: assert property (@(posedge clk_i) $rose(rst_n) |->
        !(dm_ack_o || dm_resp_valid_o || dm_reg_we_o || dm_mem_we_o || dm_op_req_o ||
          dm_halt_req_o || dm_reset_req_o))
        else abort_run("a control output was high when reset was released");

    resp_content: assert property (@(posedge clk_i) disable iff (!rst_n)
        $rose(dm_resp_valid_o) |-> dm_resp_data_o == exp_resp)
        else mismatch("dm_resp_data_o", exp_resp, $sampled(dm_resp_data_o));

    resp_once: assert property (@(posedge clk_i) disable iff (!rst_n)
        $rose(dm_resp_valid_o) |-> req_cnt == resp_cnt + 1)
        else abort_run("a response appeared without an outstanding request");

    resp_stable: assert property (@(posedge clk_i) disable iff (!rst_n)
        dm_resp_valid_o ##1 dm_resp_valid_o |-> $stable(dm_resp_data_o))
        else abort_run("response data changed while the response was valid");

    resp_held: assert property (@(posedge clk_i) disable iff (!rst_n)
        $fell(dm_resp_valid_o) |-> $past(dtm_ack_i))
        else abort_run("response valid dropped before the DTM acknowledged it");

    ack_release: assert property (@(posedge clk_i) disable iff (!rst_n)
        $fell(dm_ack_o) |-> $past(!dtm_req_valid_i))
        else abort_run("request ack dropped while the DTM still held valid");

    op_req_window: assert property (@(posedge clk_i) disable iff (!rst_n)
        $rose(dm_ack_o) |-> (dm_op_req_o == !status_read) ##1 dm_op_req_o ##1 !dm_op_req_o)
        else abort_run("dm_op_req_o did not follow the request and response cycles");

    op_req_idle: assert property (@(posedge clk_i) disable iff (!rst_n)
        !dm_ack_o |-> !dm_op_req_o)
        else abort_run("dm_op_req_o was high with no request in progress");

    halt_state: assert property (@(posedge clk_i) disable iff (!rst_n)
        $rose(dm_resp_valid_o) |-> dm_halt_req_o == exp_halt)
        else mismatch("dm_halt_req_o", exp_halt, $sampled(dm_halt_req_o));

    reg_we_total: assert property (@(posedge clk_i) disable iff (!rst_n)
        $rose(dm_resp_valid_o) |-> reg_we_cnt == exp_reg_we_cnt)
        else mismatch("dm_reg_we_o pulses", exp_reg_we_cnt, $sampled(reg_we_cnt));

    mem_we_total: assert property (@(posedge clk_i) disable iff (!rst_n)
        $rose(dm_resp_valid_o) |-> mem_we_cnt == exp_mem_we_cnt)
        else mismatch("dm_mem_we_o pulses", exp_mem_we_cnt, $sampled(mem_we_cnt));

    reset_total: assert property (@(posedge clk_i) disable iff (!rst_n)
        $rose(dm_resp_valid_o) |-> reset_cnt == exp_reset_cnt)
        else mismatch("dm_reset_req_o pulses", exp_reset_cnt, $sampled(reset_cnt));

    reg_write: assert property (@(posedge clk_i) disable iff (!rst_n)
        dm_reg_we_o |-> {dm_reg_addr_o, dm_reg_wdata_o} == {exp_reg_addr, exp_reg_wdata})
        else mismatch("{dm_reg_addr_o, dm_reg_wdata_o}", {exp_reg_addr, exp_reg_wdata},
                      $sampled({dm_reg_addr_o, dm_reg_wdata_o}));

    mem_write: assert property (@(posedge clk_i) disable iff (!rst_n)
        dm_mem_we_o |-> {dm_mem_addr_o, dm_mem_wdata_o} == {exp_mem_addr, exp_mem_wdata})
        else mismatch("{dm_mem_addr_o, dm_mem_wdata_o}", {exp_mem_addr, exp_mem_wdata},
                      $sampled({dm_mem_addr_o, dm_mem_wdata_o}));

    initial begin : stimulus
        logic [31:0] sb_words [6];
        logic [31:0] v;
        int          n;
        rst_n = 1'b0;
        dtm_req_valid_i = 1'b0;
        dtm_req_data_i = '0;
        dtm_ack_i = 1'b0;
        exp_resp = '0;
        exp_halt = 1'b0;
        exp_reg_addr = '0;
        exp_reg_wdata = '0;
        exp_mem_addr = '0;
        exp_mem_wdata = '0;
        exp_reg_we_cnt = 0;
        exp_mem_we_cnt = 0;
        exp_reset_cnt = 0;
        req_cnt = 0;
        void'($urandom(SEED));
        for (int i = 0; i < 32; i++)
            hart_exp[i] = hart_fill(i);
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_n = 1'b1;

        read_check(DM_DMSTATUS, DMSTATUS_RESET);
        read_check(6'h20, 32'h0);
        read_check(6'h3f, 32'h0);
        dmi_access(DM_DMSTATUS, DMI_OP_NOP, 32'h0, 32'h0);

        // haltreq then resumereq with dmactive kept set
        exp_halt = 1'b1;
        write_dm(DM_DMCONTROL, 32'h8000_0001);
        read_check(DM_DMSTATUS, DMSTATUS_HALT);
        exp_halt = 1'b0;
        write_dm(DM_DMCONTROL, 32'h4000_0001);
        read_check(DM_DMSTATUS, DMSTATUS_RESET);

        for (int k = 0; k < 4; k++) begin
            n = 1 + $urandom_range(30);
            v = $urandom;
            write_dm(DM_DATA0, v);
            exp_reg_addr = n[4:0];
            exp_reg_wdata = v;
            exp_reg_we_cnt = exp_reg_we_cnt + 1;
            hart_exp[n] = v;
            write_dm(DM_COMMAND, 32'h0023_1000 | n);
        end
        for (int k = 0; k < 4; k++) begin
            n = 1 + $urandom_range(30);
            write_dm(DM_COMMAND, 32'h0022_1000 | n);
            read_check(DM_DATA0, hart_exp[n]);
        end

        // aarsize 3 is not supported
        write_dm(DM_COMMAND, 32'h0032_1005);
        read_check(DM_ABSTRACTCS, ABSCS_RESET | 32'h0000_0200);

        exp_halt = 1'b1;
        write_dm(DM_DMCONTROL, 32'h8000_0001);
        exp_halt = 1'b0;
        exp_reset_cnt = exp_reset_cnt + 1;
        write_dm(DM_COMMAND, 32'h0023_07b1);
        read_check(DM_DMSTATUS, DMSTATUS_RESET);

        write_dm(DM_SBCS, SBCS_AUTO);
        read_check(DM_SBCS, SBCS_AUTO);
        write_dm(DM_SBADDRESS0, SB_BASE);
        for (int k = 0; k < 6; k++) begin
            sb_words[k] = $urandom;
            exp_mem_addr = SB_BASE + 32'(4 * k);
            exp_mem_wdata = sb_words[k];
            exp_mem_we_cnt = exp_mem_we_cnt + 1;
            write_dm(DM_SBDATA0, sb_words[k]);
        end
        write_dm(DM_SBADDRESS0, SB_BASE);
        for (int k = 0; k < 6; k++)
            read_check(DM_SBDATA0, sb_words[k]);
        read_check(DM_SBADDRESS0, SB_BASE + 32'd24);

        repeat (5) @(negedge clk_i);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/dm_cfg.svh
// DMI field widths; address is cut to 6 bits since no decoded register sits above 0x3f
`ifndef DM_CFG_SVH
`define DM_CFG_SVH

// dmi address field
`define DMI_ADDR_BITS 6

// dmi data field
`define DMI_DATA_BITS 32

// op on requests, status on responses
`define DMI_OP_BITS 2

// packed as {addr, data, op}, responses use the same layout
`define DMI_REQ_BITS (`DMI_ADDR_BITS + `DMI_DATA_BITS + `DMI_OP_BITS)

`endif

// File: src/dm_pkg.sv
// DMI encodings for a single-hart debug module; only the registers listed here are decoded
`default_nettype none

`include "dm_cfg.svh"

package dm_pkg;

    typedef enum logic [`DMI_OP_BITS-1:0] {
        DMI_OP_NOP   = 2'b00,
        DMI_OP_READ  = 2'b01,
        DMI_OP_WRITE = 2'b10
    } dmi_op_e;

    // debug module register map
    typedef enum logic [`DMI_ADDR_BITS-1:0] {
        DM_DATA0      = 6'h04,
        DM_DMCONTROL  = 6'h10,
        DM_DMSTATUS   = 6'h11,
        DM_HARTINFO   = 6'h12,
        DM_ABSTRACTCS = 6'h16,
        DM_COMMAND    = 6'h17,
        DM_SBCS       = 6'h38,
        DM_SBADDRESS0 = 6'h39,
        DM_SBDATA0    = 6'h3c
    } dm_addr_e;

    // response status, this DM always answers OK
    typedef enum logic [`DMI_OP_BITS-1:0] {
        DMI_STATUS_OK     = 2'b00,
        DMI_STATUS_FAILED = 2'b10,
        DMI_STATUS_BUSY   = 2'b11
    } dmi_status_e;

endpackage

`default_nettype wire

// File: src/dm_regs.sv
// single hart, access-register commands only; sbcs errors are never flagged and status is always OK
`timescale 1ns/1ps
`default_nettype none

`include "dm_cfg.svh"

module dm_regs (
    input  wire                      clk_i,
    input  wire                      rst_n,
    dmi_if.core                      req,
    output logic                     resp_req_o,
    output logic [`DMI_REQ_BITS-1:0] resp_data_o,
    output logic                     reg_we_o,
    output logic [4:0]               reg_addr_o,
    output logic [31:0]              reg_wdata_o,
    input  wire  [31:0]              reg_rdata_i,
    output logic                     mem_we_o,
    output logic [31:0]              mem_addr_o,
    output logic [31:0]              mem_wdata_o,
    input  wire  [31:0]              mem_rdata_i,
    output logic                     op_req_o,
    output logic                     halt_req_o,
    output logic                     reset_req_o
);
    import dm_pkg::*;

    localparam logic [31:0] DMSTATUS_RST   = 32'h0043_0c82;
    localparam logic [31:0] ABSTRACTCS_RST = 32'h0100_0003;
    localparam logic [31:0] SBCS_RST       = 32'h2004_0404;
    localparam logic [31:0] HARTINFO_VAL   = 32'h0000_0000;
    // xdebugver 4, machine mode
    localparam logic [31:0] DCSR_VAL       = 32'h4000_0003;
    // haltreq, ndmreset and dmactive read back
    localparam logic [31:0] DMCONTROL_MASK = 32'h8000_0003;
    localparam logic [15:0] REGNO_DCSR     = 16'h07b0;
    localparam logic [15:0] REGNO_DPC      = 16'h07b1;
    // upper regno bits of x0..x31 (0x1000..0x101f)
    localparam logic [10:0] REGNO_GPR      = 11'h080;

    logic [31:0]               dmstatus;
    logic [31:0]               dmcontrol;
    logic [31:0]               abstractcs;
    logic [31:0]               data0;
    logic [31:0]               sbcs;
    logic [31:0]               sbaddress0;
    logic [31:0]               sbaddress0_inc;
    logic [31:0]               rdata_d;
    logic [31:0]               rdata_q;
    logic [`DMI_ADDR_BITS-1:0] addr_q;
    logic                      gpr_rd_pend;
    logic                      is_rd;
    logic                      is_wr;
    logic                      gpr_hit;
    logic [15:0]               regno;
    dm_addr_e                  addr_e;

    assign addr_e         = dm_addr_e'(req.addr);
    assign is_rd          = req.valid && (req.op == DMI_OP_READ);
    assign is_wr          = req.valid && (req.op == DMI_OP_WRITE);
    assign regno          = req.data[15:0];
    assign gpr_hit        = (regno[15:5] == REGNO_GPR);
    assign sbaddress0_inc = sbaddress0 + 32'd4;

    // read mux, writes and nops answer with zero
    always_comb begin
        rdata_d = 32'h0;
        if (req.op == DMI_OP_READ) begin
            case (addr_e)
                DM_DMSTATUS:   rdata_d = dmstatus;
                DM_DMCONTROL:  rdata_d = dmcontrol;
                DM_HARTINFO:   rdata_d = HARTINFO_VAL;
                DM_ABSTRACTCS: rdata_d = abstractcs;
                DM_DATA0:      rdata_d = gpr_rd_pend ? reg_rdata_i : data0;
                DM_SBCS:       rdata_d = sbcs;
                DM_SBADDRESS0: rdata_d = sbaddress0;
                DM_SBDATA0:    rdata_d = mem_rdata_i;
                default:       rdata_d = 32'h0;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            resp_req_o  <= 1'b0;
            reg_we_o    <= 1'b0;
            mem_we_o    <= 1'b0;
            reset_req_o <= 1'b0;
            halt_req_o  <= 1'b0;
            reg_addr_o  <= 5'h0;
            mem_addr_o  <= 32'h0;
            dmstatus    <= DMSTATUS_RST;
            dmcontrol   <= 32'h0;
            abstractcs  <= ABSTRACTCS_RST;
            data0       <= 32'h0;
            sbcs        <= SBCS_RST;
            sbaddress0  <= 32'h0;
            gpr_rd_pend <= 1'b0;
        end else begin
            resp_req_o  <= req.valid;
            reg_we_o    <= 1'b0;
            mem_we_o    <= 1'b0;
            reset_req_o <= 1'b0;
            if (is_rd) begin
                case (addr_e)
                    DM_DATA0: gpr_rd_pend <= 1'b0;
                    DM_SBDATA0: begin
                        // advance and prefetch the next word
                        if (sbcs[16]) begin
                            sbaddress0 <= sbaddress0_inc;
                            mem_addr_o <= sbaddress0_inc;
                        end
                    end
                    default: ;
                endcase
            end
            if (is_wr) begin
                case (addr_e)
                    DM_DMCONTROL: begin
                        if (!req.data[0]) begin
                            // dmactive low, back to defaults
                            dmcontrol   <= 32'h0;
                            dmstatus    <= DMSTATUS_RST;
                            abstractcs  <= ABSTRACTCS_RST;
                            sbcs        <= SBCS_RST;
                            gpr_rd_pend <= 1'b0;
                            halt_req_o  <= 1'b0;
                        end else begin
                            dmcontrol <= req.data & DMCONTROL_MASK;
                            if (req.data[31]) begin
                                halt_req_o     <= 1'b1;
                                dmstatus[11:8] <= 4'h3;
                            end else if (req.data[30] && halt_req_o) begin
                                halt_req_o     <= 1'b0;
                                dmstatus[11:8] <= 4'hc;
                            end
                        end
                    end
                    DM_COMMAND: begin
                        // access register, cmdtype 0
                        if (req.data[31:24] == 8'h00) begin
                            if (req.data[22:20] > 3'd2) begin
                                abstractcs[9] <= 1'b1;
                            end else begin
                                abstractcs[10:8] <= 3'b000;
                                if (!req.data[16]) begin
                                    if (regno == REGNO_DCSR) begin
                                        data0 <= DCSR_VAL;
                                    end else if (gpr_hit) begin
                                        reg_addr_o  <= regno[4:0];
                                        gpr_rd_pend <= 1'b1;
                                    end
                                end else if (regno == REGNO_DPC) begin
                                    // a dpc write restarts the hart
                                    reset_req_o    <= 1'b1;
                                    halt_req_o     <= 1'b0;
                                    dmstatus[11:8] <= 4'hc;
                                end else if (gpr_hit) begin
                                    reg_addr_o <= regno[4:0];
                                    reg_we_o   <= 1'b1;
                                end
                            end
                        end
                    end
                    DM_DATA0: data0 <= req.data;
                    DM_SBCS:  sbcs  <= req.data;
                    DM_SBADDRESS0: begin
                        sbaddress0 <= req.data;
                        if (sbcs[20]) begin
                            mem_addr_o <= req.data;
                        end
                    end
                    DM_SBDATA0: begin
                        mem_addr_o <= sbaddress0;
                        mem_we_o   <= 1'b1;
                        if (sbcs[16]) begin
                            sbaddress0 <= sbaddress0_inc;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req.valid) begin
            addr_q  <= req.addr;
            rdata_q <= rdata_d;
        end
        if (is_wr && (addr_e == DM_COMMAND)) begin
            reg_wdata_o <= data0;
        end
        if (is_wr && (addr_e == DM_SBDATA0)) begin
            mem_wdata_o <= req.data;
        end
    end

    assign resp_data_o = {addr_q, rdata_q, DMI_STATUS_OK};

    // dmstatus polls do not wake the core side
    assign op_req_o = (req.valid && !(is_rd && (addr_e == DM_DMSTATUS))) || resp_req_o;

    a_we_exclusive: assert property (
        @(posedge clk_i) disable iff (!rst_n)
        !(reg_we_o && mem_we_o)
    ) else $error("register and memory write strobes overlap");

    a_resp_follows: assert property (
        @(posedge clk_i) disable iff (!rst_n)
        req.valid |=> resp_req_o
    ) else $error("request not answered in the next cycle");

endmodule

`default_nettype wire

// File: src/dmi_if.sv
// one decoded DMI request per valid pulse; the sink must take it in that cycle, no back-pressure
`timescale 1ns/1ps
`default_nettype none

`include "dm_cfg.svh"

interface dmi_if;
    import dm_pkg::*;

    // single-cycle strobe, fields below are valid with it
    logic                      valid;
    logic [`DMI_ADDR_BITS-1:0] addr;
    logic [`DMI_DATA_BITS-1:0] data;
    dmi_op_e                   op;

    modport rx (
        output valid,
        output addr,
        output data,
        output op
    );

    modport core (
        input valid,
        input addr,
        input data,
        input op
    );

endinterface

`default_nettype wire

// File: src/dmi_req_rx.sv
// req_valid_i comes from another clock domain; req_data_i must be stable while it is high
`timescale 1ns/1ps
`default_nettype none

`include "dm_cfg.svh"

module dmi_req_rx (
    input  wire                      clk_i,
    input  wire                      rst_n,
    input  wire                      req_valid_i,
    input  wire  [`DMI_REQ_BITS-1:0] req_data_i,
    output logic                     ack_o,
    dmi_if.rx                        req
);
    import dm_pkg::*;

    logic [1:0]               valid_sync;
    logic                     valid_dly;
    logic                     valid_rise;
    logic [`DMI_REQ_BITS-1:0] req_q;

    assign valid_rise = valid_sync[1] && !valid_dly;

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            valid_sync <= 2'b00;
            valid_dly  <= 1'b0;
            req.valid  <= 1'b0;
        end else begin
            valid_sync <= {valid_sync[0], req_valid_i};
            valid_dly  <= valid_sync[1];
            req.valid  <= valid_rise;
        end
    end

    // data has been stable since before valid, so sampling it here is safe
    always_ff @(posedge clk_i) begin
        if (valid_rise) begin
            req_q <= req_data_i;
        end
    end

    // ack rises with the valid pulse and drops once the DTM has released valid
    assign ack_o = valid_dly;

    assign req.addr = req_q[`DMI_REQ_BITS-1 -: `DMI_ADDR_BITS];
    assign req.data = req_q[`DMI_OP_BITS +: `DMI_DATA_BITS];
    assign req.op   = dmi_op_e'(req_q[`DMI_OP_BITS-1:0]);

    // one request per handshake, so a pulse never repeats
    a_valid_single: assert property (
        @(posedge clk_i) disable iff (!rst_n)
        req.valid |=> !req.valid
    ) else $error("dmi request valid held for more than one cycle");

endmodule

`default_nettype wire

// File: src/dmi_resp_tx.sv
// ack_i is asynchronous; only one response may be outstanding, the next waits for ack_i low
`timescale 1ns/1ps
`default_nettype none

`include "dm_cfg.svh"

module dmi_resp_tx (
    input  wire                      clk_i,
    input  wire                      rst_n,
    input  wire                      resp_req_i,
    input  wire  [`DMI_REQ_BITS-1:0] resp_data_i,
    input  wire                      ack_i,
    output logic                     valid_o,
    output logic [`DMI_REQ_BITS-1:0] data_o
);

    typedef enum logic [1:0] {
        IDLE         = 2'd0,
        WAIT_ACK     = 2'd1,
        WAIT_RELEASE = 2'd2
    } tx_state_e;

    tx_state_e  state_q;
    logic [1:0] ack_sync;

    always_ff @(posedge clk_i or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= IDLE;
            ack_sync <= 2'b00;
            valid_o  <= 1'b0;
        end else begin
            ack_sync <= {ack_sync[0], ack_i};
            case (state_q)
                IDLE: begin
                    if (resp_req_i) begin
                        valid_o <= 1'b1;
                        state_q <= WAIT_ACK;
                    end
                end
                WAIT_ACK: begin
                    if (ack_sync[1]) begin
                        valid_o <= 1'b0;
                        state_q <= WAIT_RELEASE;
                    end
                end
                WAIT_RELEASE: begin
                    // four-phase return to zero
                    if (!ack_sync[1]) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == IDLE) && resp_req_i) begin
            data_o <= resp_data_i;
        end
    end

    a_req_when_idle: assert property (
        @(posedge clk_i) disable iff (!rst_n)
        resp_req_i |-> (state_q == IDLE)
    ) else $error("response requested while transmitter busy");

    a_data_stable: assert property (
        @(posedge clk_i) disable iff (!rst_n)
        valid_o ##1 valid_o |-> $stable(data_o)
    ) else $error("response data changed while valid");

endmodule

`default_nettype wire

// File: src/jtag_dm.sv
// debug module side of the DMI link for one hart; the DTM keeps at most one request in flight
`timescale 1ns/1ps
`default_nettype none

`include "dm_cfg.svh"

module jtag_dm (
    input  wire                      clk_i,
    input  wire                      rst_n,
    input  wire                      dtm_req_valid_i,
    input  wire  [`DMI_REQ_BITS-1:0] dtm_req_data_i,
    output wire                      dm_ack_o,
    input  wire                      dtm_ack_i,
    output wire                      dm_resp_valid_o,
    output wire  [`DMI_REQ_BITS-1:0] dm_resp_data_o,
    output wire                      dm_reg_we_o,
    output wire  [4:0]               dm_reg_addr_o,
    output wire  [31:0]              dm_reg_wdata_o,
    input  wire  [31:0]              dm_reg_rdata_i,
    output wire                      dm_mem_we_o,
    output wire  [31:0]              dm_mem_addr_o,
    output wire  [31:0]              dm_mem_wdata_o,
    input  wire  [31:0]              dm_mem_rdata_i,
    output wire                      dm_op_req_o,
    output wire                      dm_halt_req_o,
    output wire                      dm_reset_req_o
);

    wire                      resp_req;
    wire [`DMI_REQ_BITS-1:0] resp_data;

    dmi_if req_if ();

    dmi_req_rx u_req_rx (
        .clk_i       (clk_i),
        .rst_n       (rst_n),
        .req_valid_i (dtm_req_valid_i),
        .req_data_i  (dtm_req_data_i),
        .ack_o       (dm_ack_o),
        .req         (req_if.rx)
    );

    dm_regs u_regs (
        .clk_i       (clk_i),
        .rst_n       (rst_n),
        .req         (req_if.core),
        .resp_req_o  (resp_req),
        .resp_data_o (resp_data),
        .reg_we_o    (dm_reg_we_o),
        .reg_addr_o  (dm_reg_addr_o),
        .reg_wdata_o (dm_reg_wdata_o),
        .reg_rdata_i (dm_reg_rdata_i),
        .mem_we_o    (dm_mem_we_o),
        .mem_addr_o  (dm_mem_addr_o),
        .mem_wdata_o (dm_mem_wdata_o),
        .mem_rdata_i (dm_mem_rdata_i),
        .op_req_o    (dm_op_req_o),
        .halt_req_o  (dm_halt_req_o),
        .reset_req_o (dm_reset_req_o)
    );

    dmi_resp_tx u_resp_tx (
        .clk_i       (clk_i),
        .rst_n       (rst_n),
        .resp_req_i  (resp_req),
        .resp_data_i (resp_data),
        .ack_i       (dtm_ack_i),
        .valid_o     (dm_resp_valid_o),
        .data_o      (dm_resp_data_o)
    );

endmodule

`default_nettype wire

// File: verilog.f
+incdir+src
src/dm_pkg.sv
src/dmi_if.sv
src/dmi_req_rx.sv
src/dm_regs.sv
src/dmi_resp_tx.sv
src/jtag_dm.sv
sim/tb_jtag_dm.sv
